//--- source/sdCardPkg.sv
package sdCardPkg;

    // ============================================================
    // Field widths
    // ============================================================

    typedef logic [5:0]  cmdIndexT;
    typedef logic [31:0] cmdArgT;
    typedef logic [6:0]  crc7T;
    typedef logic [15:0] crc16T;
    typedef logic [15:0] rcaT;
    typedef logic [3:0]  nibbleT;

    // ============================================================
    // Command indices
    // ============================================================

    localparam cmdIndexT CmdGoIdle     = 6'd0;
    localparam cmdIndexT CmdSendRca    = 6'd3;
    localparam cmdIndexT CmdSelect     = 6'd7;
    localparam cmdIndexT CmdIfCond     = 6'd8;
    localparam cmdIndexT CmdStop       = 6'd12;
    localparam cmdIndexT CmdWriteMulti = 6'd25;
    localparam cmdIndexT CmdApp        = 6'd55;

    // Application command, only decoded right after CMD55
    localparam cmdIndexT AcmdOpCond    = 6'd41;

    // ============================================================
    // Response arguments
    // ============================================================

    // Address handed out by CMD3
    localparam rcaT CardRca = 16'hAAAA;

    // R1 card status, transfer state with ready for data
    localparam cmdArgT StatusReady  = 32'h0000_0900;

    // Same status with the APP_CMD bit set
    localparam cmdArgT StatusAppCmd = 32'h0000_0920;

    // OCR with power-up done and high capacity
    localparam cmdArgT OcrReady     = 32'hC1FF_8080;

    // ============================================================
    // CRC status tokens
    // ============================================================

    // Sent MSB first on DAT0
    localparam logic [4:0] TokenOk  = 5'b00101;
    localparam logic [4:0] TokenBad = 5'b01011;

endpackage

//--- source/cardCtrlIf.sv
`timescale 1ns/1ps

interface cardCtrlIf;

    logic writeActive;  // Card is in a CMD25 write
    logic stopBusy;     // CMD12 ended a write
    logic blockDone;    // One block fully received
    logic crcOk;        // Verdict for the last block
    logic lineBusy;     // DAT lines driven by the card

    modport cmdSide (output writeActive, output stopBusy);

    modport writeSide (input writeActive, input lineBusy, output blockDone, output crcOk);

    modport driverSide (input blockDone, input crcOk, input stopBusy, output lineBusy);

endinterface

//--- source/cmdResponder.sv
`timescale 1ns/1ps

module cmdResponder
    import sdCardPkg::*;
#(
    parameter int NcrCycles = 2     // At least 2
) (
    input  logic       clk,
    input  logic       rst_,
    input  logic       cmdIn,
    output logic       cmdOut,
    output logic       cmdOe,
    output logic       cmdError,
    cardCtrlIf.cmdSide ctrl
);

    typedef enum logic [2:0] {stIdle, stReceive, stCheck, stWait, stSend} cmdStateT;

    localparam int WaitW = (NcrCycles > 2) ? $clog2(NcrCycles - 1) : 1;
    localparam cmdIndexT OcrIndex = 6'd63;

    cmdStateT         state;
    logic [5:0]       bitCnt;
    logic [WaitW-1:0] waitCnt;
    logic [47:0]      rxShift;
    logic [47:0]      txShift;
    logic             txUseCrc;
    crc7T             crcReg;
    rcaT              rca;
    logic             appPending;
    logic             startWrite;

    // Decoded view of the received frame
    cmdIndexT rxIndex;
    cmdArgT   rxArg;
    logic     frameOk;
    logic     cmdKnown;
    logic     cmdValid;
    logic     needResp;
    logic     respCrc;
    cmdIndexT respIndex;
    cmdArgT   respArg;

    function automatic crc7T crc7Next(crc7T crc, logic bitIn);
        logic fb;
        fb = bitIn ^ crc[6];
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

    // ============================================================
    // Command decode and response table
    // ============================================================

    always_comb begin
        rxIndex   = rxShift[45:40];
        rxArg     = rxShift[39:8];
        frameOk   = (rxShift[47:46] == 2'b01) && (rxShift[7:1] == crcReg) && rxShift[0];
        cmdKnown  = 1'b1;
        needResp  = 1'b1;
        respCrc   = 1'b1;
        respIndex = rxIndex;
        respArg   = StatusReady;
        if (appPending && rxIndex == AcmdOpCond) begin
            // R3 carries no CRC
            respIndex = OcrIndex;
            respArg   = OcrReady;
            respCrc   = 1'b0;
        end else begin
            case (rxIndex)
                CmdGoIdle:              needResp = 1'b0;
                CmdSendRca:             respArg = {CardRca, 16'h0500};
                CmdSelect:              cmdKnown = (rxArg[31:16] == rca);
                CmdIfCond:              respArg = rxArg;
                CmdStop, CmdWriteMulti: respArg = StatusReady;
                CmdApp:                 respArg = StatusAppCmd;
                default:                cmdKnown = 1'b0;
            endcase
        end
        cmdValid = frameOk && cmdKnown;
    end

    assign cmdOut = txShift[47];

    // ============================================================
    // Control FSM
    // ============================================================

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state            <= stIdle;
            bitCnt           <= '0;
            waitCnt          <= '0;
            cmdOe            <= 1'b0;
            cmdError         <= 1'b0;
            rca              <= '0;
            appPending       <= 1'b0;
            startWrite       <= 1'b0;
            ctrl.writeActive <= 1'b0;
            ctrl.stopBusy    <= 1'b0;
        end else begin
            cmdError      <= 1'b0;
            ctrl.stopBusy <= 1'b0;
            case (state)
                stIdle: begin
                    if (!cmdIn) begin
                        state  <= stReceive;
                        bitCnt <= 6'd1;
                    end
                end
                stReceive: begin
                    bitCnt <= bitCnt + 6'd1;
                    if (bitCnt == 6'd47) begin
                        state <= stCheck;
                    end
                end
                stCheck: begin
                    appPending <= cmdValid && (rxIndex == CmdApp);
                    startWrite <= cmdValid && (rxIndex == CmdWriteMulti);
                    if (cmdValid && rxIndex == CmdSendRca) begin
                        rca <= CardRca;
                    end
                    if (cmdValid && rxIndex == CmdStop) begin
                        ctrl.writeActive <= 1'b0;
                        ctrl.stopBusy    <= ctrl.writeActive;
                    end
                    if (!cmdValid) begin
                        cmdError <= 1'b1;
                        state    <= stIdle;
                    end else if (!needResp) begin
                        state <= stIdle;
                    end else begin
                        state   <= stWait;
                        waitCnt <= WaitW'(NcrCycles - 2);
                    end
                end
                stWait: begin
                    if (waitCnt == '0) begin
                        state  <= stSend;
                        cmdOe  <= 1'b1;
                        bitCnt <= '0;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                stSend: begin
                    bitCnt <= bitCnt + 6'd1;
                    if (bitCnt == 6'd47) begin
                        state      <= stIdle;
                        cmdOe      <= 1'b0;
                        startWrite <= 1'b0;
                        // Write window opens once the CMD25 response is out
                        if (startWrite) begin
                            ctrl.writeActive <= 1'b1;
                        end
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // ============================================================
    // Shift registers and CRC7
    // ============================================================

    always_ff @(posedge clk) begin
        case (state)
            stIdle: begin
                rxShift <= {rxShift[46:0], cmdIn};
                crcReg  <= '0;
            end
            stReceive: begin
                rxShift <= {rxShift[46:0], cmdIn};
                if (bitCnt < 6'd40) begin
                    crcReg <= crc7Next(crcReg, cmdIn);
                end
            end
            stCheck: begin
                txShift  <= {2'b00, respIndex, respArg, 7'h7F, 1'b1};
                txUseCrc <= respCrc;
                crcReg   <= '0;
            end
            stSend: begin
                if (bitCnt < 6'd40) begin
                    crcReg <= crc7Next(crcReg, txShift[47]);
                end
                // Splice in the CRC right after the 40th bit
                if (bitCnt == 6'd39 && txUseCrc) begin
                    txShift <= {crc7Next(crcReg, txShift[47]), 1'b1, txShift[39:0]};
                end else begin
                    txShift <= {txShift[46:0], 1'b1};
                end
            end
            default: begin
                rxShift <= rxShift;
            end
        endcase
    end

endmodule

//--- source/writeReceiver.sv
`timescale 1ns/1ps

module writeReceiver
    import sdCardPkg::*;
#(
    parameter int BlockNibbles = 1024
) (
    input  logic         clk,
    input  logic         rst_,
    input  nibbleT       datIn,
    cardCtrlIf.writeSide ctrl
);

    typedef enum logic [1:0] {stIdle, stData, stCrc, stEndBits} writeStateT;

    // Wide enough for the data count and the 16 CRC nibbles
    localparam int CntW = (BlockNibbles > 16) ? $clog2(BlockNibbles) : 4;
    localparam logic [CntW-1:0] LastData = CntW'(BlockNibbles - 1);
    localparam logic [CntW-1:0] LastCrc  = CntW'(15);

    writeStateT      state;
    logic [CntW-1:0] nibCnt;
    logic            endSeen;
    logic            crcMatch;
    crc16T           ourCrc   [4];
    crc16T           theirCrc [4];

    function automatic crc16T crc16Next(crc16T crc, logic bitIn);
        logic fb;
        fb = bitIn ^ crc[15];
        return {crc[14:12], crc[11] ^ fb, crc[10:5], crc[4] ^ fb, crc[3:0], fb};
    endfunction

    always_comb begin
        crcMatch = 1'b1;
        for (int lane = 0; lane < 4; lane++) begin
            if (ourCrc[lane] != theirCrc[lane]) begin
                crcMatch = 1'b0;
            end
        end
    end

    // ============================================================
    // Block framing
    // ============================================================

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state          <= stIdle;
            nibCnt         <= '0;
            endSeen        <= 1'b0;
            ctrl.blockDone <= 1'b0;
            ctrl.crcOk     <= 1'b0;
        end else begin
            endSeen        <= 1'b0;
            ctrl.blockDone <= endSeen && ctrl.writeActive;
            if (!ctrl.writeActive) begin
                // Stop command drops a partial block
                state <= stIdle;
            end else begin
                case (state)
                    stIdle: begin
                        if (!ctrl.lineBusy && !datIn[0]) begin
                            state  <= stData;
                            nibCnt <= '0;
                        end
                    end
                    stData: begin
                        if (nibCnt == LastData) begin
                            state  <= stCrc;
                            nibCnt <= '0;
                        end else begin
                            nibCnt <= nibCnt + 1'b1;
                        end
                    end
                    stCrc: begin
                        if (nibCnt == LastCrc) begin
                            state <= stEndBits;
                        end else begin
                            nibCnt <= nibCnt + 1'b1;
                        end
                    end
                    stEndBits: begin
                        state      <= stIdle;
                        endSeen    <= 1'b1;
                        ctrl.crcOk <= crcMatch && (&datIn);
                    end
                    default: state <= stIdle;
                endcase
            end
        end
    end

    // ============================================================
    // Per-lane CRC16
    // ============================================================

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (state == stIdle) begin
                ourCrc[lane] <= '0;
            end else if (state == stData) begin
                ourCrc[lane] <= crc16Next(ourCrc[lane], datIn[lane]);
            end else if (state == stCrc) begin
                theirCrc[lane] <= {theirCrc[lane][14:0], datIn[lane]};
            end
        end
    end

endmodule

//--- source/datLineDriver.sv
`timescale 1ns/1ps

module datLineDriver
    import sdCardPkg::*;
#(
    parameter int NcrcCycles = 2,   // At least 2
    parameter int BusyCycles = 8
) (
    input  logic          clk,
    input  logic          rst_,
    output nibbleT        datOut,
    output logic          datOe,
    cardCtrlIf.driverSide ctrl
);

    typedef enum logic [2:0] {stIdle, stDelay, stToken, stBusy, stRelease} drvStateT;

    localparam int StopDelay = 2;
    localparam int DelayW    = (NcrcCycles > 2) ? $clog2(NcrcCycles - 1) : 1;
    localparam int PhaseW    = $clog2((BusyCycles > 5) ? BusyCycles : 5);

    drvStateT          state;
    logic [DelayW-1:0] delayCnt;
    logic [PhaseW-1:0] phaseCnt;
    logic              withToken;
    logic [4:0]        tokenReg;
    logic              lineBit;

    // Outputs follow the state directly
    assign datOe         = (state == stToken) || (state == stBusy) || (state == stRelease);
    assign lineBit       = (state == stToken) ? tokenReg[4] : (state == stRelease);
    assign datOut        = {3'b000, lineBit};
    assign ctrl.lineBusy = (state != stIdle);

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state     <= stIdle;
            delayCnt  <= '0;
            phaseCnt  <= '0;
            withToken <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (ctrl.blockDone) begin
                        state     <= stDelay;
                        withToken <= 1'b1;
                        delayCnt  <= DelayW'(NcrcCycles - 2);
                    end else if (ctrl.stopBusy) begin
                        state     <= stDelay;
                        withToken <= 1'b0;
                        delayCnt  <= DelayW'(StopDelay - 2);
                    end
                end
                stDelay: begin
                    phaseCnt <= '0;
                    if (delayCnt == '0) begin
                        state <= withToken ? stToken : stBusy;
                    end else begin
                        delayCnt <= delayCnt - 1'b1;
                    end
                end
                stToken: begin
                    if (phaseCnt == PhaseW'(4)) begin
                        state    <= stBusy;
                        phaseCnt <= '0;
                    end else begin
                        phaseCnt <= phaseCnt + 1'b1;
                    end
                end
                stBusy: begin
                    if (phaseCnt == PhaseW'(BusyCycles - 1)) begin
                        state    <= stRelease;
                        phaseCnt <= '0;
                    end else begin
                        phaseCnt <= phaseCnt + 1'b1;
                    end
                end
                stRelease: begin
                    // Two cycles of a driven 1 before letting go
                    if (phaseCnt == PhaseW'(1)) begin
                        state <= stIdle;
                    end else begin
                        phaseCnt <= phaseCnt + 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && ctrl.blockDone) begin
            tokenReg <= ctrl.crcOk ? TokenOk : TokenBad;
        end else if (state == stToken) begin
            tokenReg <= {tokenReg[3:0], 1'b0};
        end
    end

endmodule

//--- source/sdCardTop.sv
`timescale 1ns/1ps

module sdCardTop
    import sdCardPkg::*;
#(
    parameter int NcrCycles    = 2,
    parameter int NcrcCycles   = 2,
    parameter int BusyCycles   = 8,
    parameter int BlockNibbles = 1024
) (
    input  logic   clk,
    input  logic   rst_,
    input  logic   cmdIn,
    input  nibbleT datIn,
    output logic   cmdOut,
    output logic   cmdOe,
    output nibbleT datOut,
    output logic   datOe,
    output logic   cmdError
);

    // Strobes between the command, write and DAT sides
    cardCtrlIf ctrlBus ();

    cmdResponder #(
        .NcrCycles (NcrCycles)
    ) cmdResp (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdOut   (cmdOut),
        .cmdOe    (cmdOe),
        .cmdError (cmdError),
        .ctrl     (ctrlBus.cmdSide)
    );

    writeReceiver #(
        .BlockNibbles (BlockNibbles)
    ) writeRx (
        .clk   (clk),
        .rst_  (rst_),
        .datIn (datIn),
        .ctrl  (ctrlBus.writeSide)
    );

    datLineDriver #(
        .NcrcCycles (NcrcCycles),
        .BusyCycles (BusyCycles)
    ) datDrv (
        .clk    (clk),
        .rst_   (rst_),
        .datOut (datOut),
        .datOe  (datOe),
        .ctrl   (ctrlBus.driverSide)
    );

endmodule

//--- bench/sdCardChecker.sv
`timescale 1ns/1ps

module sdCardChecker
    import sdCardPkg::*;
(
    input logic   clk,
    input logic   cmdOut,
    input logic   cmdOe,
    input nibbleT datOut,
    input logic   datOe,
    input logic   cmdError
);

    localparam int Depth = 128;

    int         cyc = 0;
    int         base;
    int         idx;
    int         passCount = 0;
    int         failCount = 0;
    bit         active = 1'b0;
    bit         failed;
    string      testName;
    string      failText;
    logic [4:0] expv;

    // Per cycle of a test: {cmdOe, cmdOut, cmdError, datOe, datOut[0]}
    logic [4:0] expVec [Depth];

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ============================================================
    // Expectations posted by the model
    // ============================================================

    task automatic openTest(input string name);
        foreach (expVec[i]) begin
            expVec[i] = '0;
        end
        base     = cyc;
        testName = name;
        failed   = 1'b0;
        active   = 1'b1;
    endtask

    task automatic expectResp(input int start, input logic [47:0] resp);
        for (int k = 0; k < 48; k++) begin
            expVec[start - base + k][4:3] = {1'b1, resp[47 - k]};
        end
    endtask

    task automatic expectError(input int at);
        expVec[at - base][2] = 1'b1;
    endtask

    task automatic expectDat(input int start, input bit withToken, input logic [4:0] token,
                             input int busyLen);
        int at;
        at = start - base;
        if (withToken) begin
            for (int k = 0; k < 5; k++) begin
                expVec[at + k][1:0] = {1'b1, token[4 - k]};
            end
            at = at + 5;
        end
        for (int k = 0; k < busyLen; k++) begin
            expVec[at + k][1:0] = 2'b10;
        end
        // Release phase drives 1 for two cycles
        expVec[at + busyLen][1:0]     = 2'b11;
        expVec[at + busyLen + 1][1:0] = 2'b11;
    endtask

    task automatic closeTest();
        if (failed) begin
            $display("%s", failText);
            failCount++;
        end else begin
            $display("Test %s ok", testName);
            passCount++;
        end
        active = 1'b0;
    endtask

    task automatic reportTotals();
        $display("Tests run %0d, passed %0d, with errors %0d",
                 passCount + failCount, passCount, failCount);
    endtask

    // ============================================================
    // Comparison, sampled mid-cycle
    // ============================================================

    function automatic string eventText(string sig, logic wanted, int at);
        return $sformatf("Test %s: %s %s at cycle %0d of the test", testName, sig,
                         wanted ? "did not go high" : "went high unexpectedly", at);
    endfunction

    always @(negedge clk) begin
        if (active && !failed) begin
            idx  = cyc - base;
            expv = (idx < Depth) ? expVec[idx] : 5'b0;
            failed = 1'b1;
            if (cmdOe !== expv[4]) begin
                failText = eventText("cmdOe", expv[4], idx);
            end else if (cmdError !== expv[2]) begin
                failText = eventText("cmdError", expv[2], idx);
            end else if (datOe !== expv[1]) begin
                failText = eventText("datOe", expv[1], idx);
            end else if (expv[4] && cmdOut !== expv[3]) begin
                failText = $sformatf("Error %s expected cmdOut=%b actual %b at cycle %0d",
                                     testName, expv[3], cmdOut, idx);
            end else if (expv[1] && datOut !== {3'b000, expv[0]}) begin
                failText = $sformatf("Error %s expected datOut=%h actual %h at cycle %0d",
                                     testName, {3'b000, expv[0]}, datOut, idx);
            end else begin
                failed = 1'b0;
            end
        end
    end

endmodule

//--- bench/sdCardTb.sv
`timescale 1ns/1ps

module sdCardTb
    import sdCardPkg::*;
();

    localparam int NcrCycles    = 2;
    localparam int NcrcCycles   = 2;
    localparam int BusyCycles   = 8;
    localparam int BlockNibbles = 16;

    // Idle tail after each test so that every output is seen to fall
    localparam int CmdTail      = NcrCycles + 50;
    localparam int BlockTail    = NcrcCycles + BusyCycles + 10;
    localparam int CmdTestLen   = 48 + CmdTail;
    localparam int BlockTestLen = BlockNibbles + 18 + BlockTail;
    localparam int CycleLimit   = 2 * (14 * CmdTestLen + 6 * BlockTestLen + 4);
    localparam logic [31:0] Seed = 32'h2b7318a2;

    logic   clk = 1'b0;
    logic   rst_;
    logic   cmdIn;
    nibbleT datIn;
    logic   cmdOut;
    logic   cmdOe;
    nibbleT datOut;
    logic   datOe;
    logic   cmdError;

    sdCardTop #(
        .BlockNibbles (BlockNibbles)
    ) uut (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .datIn    (datIn),
        .cmdOut   (cmdOut),
        .cmdOe    (cmdOe),
        .datOut   (datOut),
        .datOe    (datOe),
        .cmdError (cmdError)
    );

    sdCardChecker chk (
        .clk      (clk),
        .cmdOut   (cmdOut),
        .cmdOe    (cmdOe),
        .datOut   (datOut),
        .datOe    (datOe),
        .cmdError (cmdError)
    );

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (chk.cyc > CycleLimit) begin
            $display("Run stopped at cycle %0d before the test sequence ended", chk.cyc);
            $display("Verification failed");
            $finish;
        end
    end

    // ============================================================
    // Reference CRCs and frame builders
    // ============================================================

    // CRC7 over x^7 + x^3 + 1 from a zero start
    function automatic crc7T crc7Of(logic [39:0] bits);
        crc7T crc;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            crc = {crc[5:0], 1'b0} ^ ((bits[i] ^ crc[6]) ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    // CRC16 over x^16 + x^12 + x^5 + 1 one bit at a time
    function automatic crc16T crc16Step(crc16T crc, logic b);
        return {crc[14:0], 1'b0} ^ ((b ^ crc[15]) ? 16'h1021 : 16'h0000);
    endfunction

    function automatic logic [47:0] cmdFrame(cmdIndexT index, cmdArgT arg);
        logic [39:0] head;
        head = {2'b01, index, arg};
        return {head, crc7Of(head), 1'b1};
    endfunction

    function automatic logic [47:0] respFrame(cmdIndexT index, cmdArgT arg, bit crcOn);
        logic [39:0] head;
        head = {2'b00, index, arg};
        return {head, crcOn ? crc7Of(head) : 7'h7F, 1'b1};
    endfunction

    // ============================================================
    // Host tasks
    // ============================================================

    task automatic stepCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runCmd(input string name, input logic [47:0] frame, input bit respOn,
                          input logic [47:0] resp, input bit errOn, input bit busyOn);
        int endCyc;
        endCyc = chk.cyc + 48;
        chk.openTest(name);
        if (respOn) begin
            chk.expectResp(endCyc + NcrCycles, resp);
        end
        if (errOn) begin
            chk.expectError(endCyc + 1);
        end
        if (busyOn) begin
            // One cycle for the stop strobe and two more to the busy start
            chk.expectDat(endCyc + 3, 1'b0, 5'b0, BusyCycles);
        end
        for (int k = 47; k >= 0; k--) begin
            cmdIn = frame[k];
            stepCycles(1);
        end
        cmdIn = 1'b1;
        stepCycles(CmdTail);
        chk.closeTest();
    endtask

    // Fault 0 is a clean block, 1 a corrupted data nibble and 2 a bad end bit
    task automatic runBlock(input string name, input int fault, input bit expectOn);
        nibbleT data [BlockNibbles];
        crc16T  crc [4];
        nibbleT endNib;
        int     badPos;
        int     endCyc;
        for (int lane = 0; lane < 4; lane++) begin
            crc[lane] = '0;
        end
        for (int j = 0; j < BlockNibbles; j++) begin
            data[j] = nibbleT'($urandom);
            for (int lane = 0; lane < 4; lane++) begin
                crc[lane] = crc16Step(crc[lane], data[j][lane]);
            end
        end
        endNib = 4'hF;
        if (fault == 1) begin
            badPos = $urandom_range(BlockNibbles - 1, 0);
            data[badPos] = data[badPos] ^ nibbleT'($urandom_range(15, 1));
        end else if (fault == 2) begin
            endNib[$urandom_range(3, 0)] = 1'b0;
        end
        endCyc = chk.cyc + BlockNibbles + 18;
        chk.openTest(name);
        if (expectOn) begin
            chk.expectDat(endCyc + 1 + NcrcCycles, 1'b1, (fault == 0) ? TokenOk : TokenBad,
                          BusyCycles);
        end
        datIn = 4'h0;
        stepCycles(1);
        for (int j = 0; j < BlockNibbles; j++) begin
            datIn = data[j];
            stepCycles(1);
        end
        for (int b = 15; b >= 0; b--) begin
            datIn = {crc[3][b], crc[2][b], crc[1][b], crc[0][b]};
            stepCycles(1);
        end
        datIn = endNib;
        stepCycles(1);
        datIn = 4'hF;
        stepCycles(BlockTail);
        chk.closeTest();
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        cmdArgT      arg;
        cmdIndexT    index;
        rcaT         badRca;
        logic [47:0] frame;
        int          flipPos;
        rst_  = 1'b0;
        cmdIn = 1'b1;
        datIn = 4'hF;
        void'($urandom(Seed));
        repeat (2) @(posedge clk);
        #1;
        rst_ = 1'b1;
        stepCycles(2);

        runCmd("cmd0", cmdFrame(CmdGoIdle, $urandom), 1'b0, '0, 1'b0, 1'b0);
        arg = $urandom;
        runCmd("cmd8", cmdFrame(CmdIfCond, arg), 1'b1, respFrame(CmdIfCond, arg, 1'b1),
               1'b0, 1'b0);
        runCmd("cmd3", cmdFrame(CmdSendRca, $urandom), 1'b1,
               respFrame(CmdSendRca, {CardRca, 16'h0500}, 1'b1), 1'b0, 1'b0);
        runCmd("cmd55", cmdFrame(CmdApp, $urandom), 1'b1,
               respFrame(CmdApp, StatusAppCmd, 1'b1), 1'b0, 1'b0);
        runCmd("acmd41", cmdFrame(AcmdOpCond, $urandom), 1'b1,
               respFrame(6'd63, OcrReady, 1'b0), 1'b0, 1'b0);
        runCmd("acmd41_alone", cmdFrame(AcmdOpCond, $urandom), 1'b0, '0, 1'b1, 1'b0);

        for (int n = 0; n < 3; n++) begin
            frame   = cmdFrame(CmdIfCond, $urandom);
            flipPos = $urandom_range(46, 0);
            frame[flipPos] = ~frame[flipPos];
            runCmd($sformatf("flip_bit_%0d", flipPos), frame, 1'b0, '0, 1'b1, 1'b0);
        end

        do begin
            index = cmdIndexT'($urandom);
        end while (index inside {CmdGoIdle, CmdSendRca, CmdSelect, CmdIfCond, CmdStop,
                                 CmdWriteMulti, CmdApp});
        runCmd($sformatf("unknown_cmd%0d", index), cmdFrame(index, $urandom), 1'b0, '0,
               1'b1, 1'b0);

        runCmd("cmd7_own_rca", cmdFrame(CmdSelect, {CardRca, rcaT'($urandom)}), 1'b1,
               respFrame(CmdSelect, StatusReady, 1'b1), 1'b0, 1'b0);
        do begin
            badRca = rcaT'($urandom);
        end while (badRca == CardRca);
        runCmd("cmd7_wrong_rca", cmdFrame(CmdSelect, {badRca, 16'h0000}), 1'b0, '0,
               1'b1, 1'b0);

        runCmd("cmd25", cmdFrame(CmdWriteMulti, $urandom), 1'b1,
               respFrame(CmdWriteMulti, StatusReady, 1'b1), 1'b0, 1'b0);
        for (int n = 0; n < 3; n++) begin
            runBlock($sformatf("block_ok_%0d", n), 0, 1'b1);
        end
        runBlock("block_bad_data", 1, 1'b1);
        runBlock("block_bad_end", 2, 1'b1);

        runCmd("cmd12_stop", cmdFrame(CmdStop, $urandom), 1'b1,
               respFrame(CmdStop, StatusReady, 1'b1), 1'b0, 1'b1);
        runBlock("block_after_stop", 0, 1'b0);

        chk.reportTotals();
        if (chk.failCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- compile.f
source/sdCardPkg.sv
source/cardCtrlIf.sv
source/cmdResponder.sv
source/writeReceiver.sv
source/datLineDriver.sv
source/sdCardTop.sv
bench/sdCardChecker.sv
bench/sdCardTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module sdCardTb -o simv

output="$(./obj_dir/simv)"
echo "$output"

echo "$output" | grep -q "Verification passed"
